/* common/e0c62_defs.svh */
`ifndef E0C62_DEFS_SVH
`define E0C62_DEFS_SVH

`define E0C62_NIBBLE_W   4
`define E0C62_INSTR_W    12
`define E0C62_PC_W       12
`define E0C62_ADDR_W     8
`define E0C62_RAM_DEPTH  256

// Match masks per instruction form
`define E0C62_MASK_RQ    12'hFF0
`define E0C62_MASK_RI    12'hFC0
`define E0C62_MASK_MR    12'hFFC
`define E0C62_MASK_LE    12'hF00
`define E0C62_MASK_ALL   12'hFFF

`define E0C62_OP_ADD_RQ  12'hA80
`define E0C62_OP_ADC_RQ  12'hA90
`define E0C62_OP_SUB_RQ  12'hAA0
`define E0C62_OP_SBC_RQ  12'hAB0
`define E0C62_OP_ADD_RI  12'hC00
`define E0C62_OP_ADC_RI  12'hC40
`define E0C62_OP_SBC_RI  12'hD40
`define E0C62_OP_ACPX    12'hF28
`define E0C62_OP_ACPY    12'hF2C
`define E0C62_OP_SCPX    12'hF38
`define E0C62_OP_SCPY    12'hF3C
`define E0C62_OP_LD_RI   12'hE00
`define E0C62_OP_LD_XE   12'hB00
`define E0C62_OP_LD_YE   12'h800
`define E0C62_OP_SCF     12'hF41
`define E0C62_OP_RCF     12'hF5E
`define E0C62_OP_SDF     12'hF44
`define E0C62_OP_RDF     12'hF5B

`endif

/* common/e0c62_pkg.sv */
`include "e0c62_defs.svh"

package e0c62_pkg;

  typedef logic [`E0C62_NIBBLE_W-1:0] nibble_t;
  typedef logic [`E0C62_INSTR_W-1:0]  instr_t;
  typedef logic [`E0C62_PC_W-1:0]     pc_t;
  typedef logic [`E0C62_ADDR_W-1:0]   ram_addr_t;

  // 0 A, 1 B, 2 MX, 3 MY
  typedef logic [1:0] opnd_sel_t;

  typedef enum logic [2:0] {
    NOP,
    LOAD_R,
    LOAD_X,
    LOAD_Y,
    ADD,
    SUB,
    SET_FLAG,
    CLR_FLAG
  } exec_op_t;

  typedef enum logic {
    FLAG_CARRY,
    FLAG_DECIMAL
  } flag_sel_t;

endpackage

/* verilog/fetch_stage.sv */
module fetch_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              run,
  output e0c62_pkg::pc_t    rom_addr,
  input  e0c62_pkg::instr_t rom_data,
  output logic              f_valid,
  output e0c62_pkg::pc_t    f_pc,
  output e0c62_pkg::instr_t f_instr
);

  e0c62_pkg::pc_t pc;

  assign rom_addr = pc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc      <= '0;
      f_valid <= 1'b0;
    end else begin
      f_valid <= run; // Bubble while halted
      if (run) begin
        pc <= pc + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (run) begin
      f_pc    <= pc;
      f_instr <= rom_data;
    end
  end

endmodule

/* decode/decode_stage.sv */
`include "e0c62_defs.svh"

module decode_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 f_valid,
  input  e0c62_pkg::pc_t       f_pc,
  input  e0c62_pkg::instr_t    f_instr,
  output logic                 d_valid,
  output e0c62_pkg::pc_t       d_pc,
  output e0c62_pkg::exec_op_t  d_op,
  output e0c62_pkg::opnd_sel_t d_dst,
  output e0c62_pkg::opnd_sel_t d_src,
  output logic                 d_use_imm,
  output e0c62_pkg::nibble_t   d_imm,
  output logic                 d_use_carry,
  output logic                 d_cmp_x,
  output logic                 d_cmp_y,
  output e0c62_pkg::flag_sel_t d_flag,
  output e0c62_pkg::ram_addr_t d_addr_imm
);

  e0c62_pkg::exec_op_t  op_n;
  e0c62_pkg::opnd_sel_t dst_n;
  e0c62_pkg::opnd_sel_t src_n;
  e0c62_pkg::flag_sel_t flag_n;
  logic                 use_imm_n;
  logic                 use_carry_n;
  logic                 cmp_x_n;
  logic                 cmp_y_n;

  function automatic logic hit(e0c62_pkg::instr_t word, e0c62_pkg::instr_t mask,
                               e0c62_pkg::instr_t base);
    return (word & mask) == base;
  endfunction

  always_comb begin
    op_n        = e0c62_pkg::NOP; // Unmatched words retire as NOP
    dst_n       = f_instr[3:2];
    src_n       = f_instr[1:0];
    flag_n      = e0c62_pkg::FLAG_CARRY;
    use_imm_n   = 1'b0;
    use_carry_n = 1'b0;
    cmp_x_n     = 1'b0;
    cmp_y_n     = 1'b0;
    if (hit(f_instr, `E0C62_MASK_RQ, `E0C62_OP_ADD_RQ)) begin
      op_n = e0c62_pkg::ADD;
    end else if (hit(f_instr, `E0C62_MASK_RQ, `E0C62_OP_ADC_RQ)) begin
      op_n        = e0c62_pkg::ADD;
      use_carry_n = 1'b1;
    end else if (hit(f_instr, `E0C62_MASK_RQ, `E0C62_OP_SUB_RQ)) begin
      op_n = e0c62_pkg::SUB;
    end else if (hit(f_instr, `E0C62_MASK_RQ, `E0C62_OP_SBC_RQ)) begin
      op_n        = e0c62_pkg::SUB;
      use_carry_n = 1'b1;
    end else if (hit(f_instr, `E0C62_MASK_RI, `E0C62_OP_ADD_RI)) begin
      op_n      = e0c62_pkg::ADD;
      dst_n     = f_instr[5:4];
      use_imm_n = 1'b1;
    end else if (hit(f_instr, `E0C62_MASK_RI, `E0C62_OP_ADC_RI)) begin
      op_n        = e0c62_pkg::ADD;
      dst_n       = f_instr[5:4];
      use_imm_n   = 1'b1;
      use_carry_n = 1'b1;
    end else if (hit(f_instr, `E0C62_MASK_RI, `E0C62_OP_SBC_RI)) begin
      op_n        = e0c62_pkg::SUB;
      dst_n       = f_instr[5:4];
      use_imm_n   = 1'b1;
      use_carry_n = 1'b1;
    end else if (hit(f_instr, `E0C62_MASK_MR, `E0C62_OP_ACPX) ||
                 hit(f_instr, `E0C62_MASK_MR, `E0C62_OP_SCPX)) begin
      op_n        = f_instr[4] ? e0c62_pkg::SUB : e0c62_pkg::ADD; // SCPX has bit 4 set
      dst_n       = 2'd2;
      use_carry_n = 1'b1;
      cmp_x_n     = 1'b1;
    end else if (hit(f_instr, `E0C62_MASK_MR, `E0C62_OP_ACPY) ||
                 hit(f_instr, `E0C62_MASK_MR, `E0C62_OP_SCPY)) begin
      op_n        = f_instr[4] ? e0c62_pkg::SUB : e0c62_pkg::ADD;
      dst_n       = 2'd3;
      use_carry_n = 1'b1;
      cmp_y_n     = 1'b1;
    end else if (hit(f_instr, `E0C62_MASK_RI, `E0C62_OP_LD_RI)) begin
      op_n  = e0c62_pkg::LOAD_R;
      dst_n = f_instr[5:4];
    end else if (hit(f_instr, `E0C62_MASK_LE, `E0C62_OP_LD_XE)) begin
      op_n = e0c62_pkg::LOAD_X;
    end else if (hit(f_instr, `E0C62_MASK_LE, `E0C62_OP_LD_YE)) begin
      op_n = e0c62_pkg::LOAD_Y;
    end else if (hit(f_instr, `E0C62_MASK_ALL, `E0C62_OP_SCF)) begin
      op_n = e0c62_pkg::SET_FLAG;
    end else if (hit(f_instr, `E0C62_MASK_ALL, `E0C62_OP_RCF)) begin
      op_n = e0c62_pkg::CLR_FLAG;
    end else if (hit(f_instr, `E0C62_MASK_ALL, `E0C62_OP_SDF)) begin
      op_n   = e0c62_pkg::SET_FLAG;
      flag_n = e0c62_pkg::FLAG_DECIMAL;
    end else if (hit(f_instr, `E0C62_MASK_ALL, `E0C62_OP_RDF)) begin
      op_n   = e0c62_pkg::CLR_FLAG;
      flag_n = e0c62_pkg::FLAG_DECIMAL;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d_valid <= 1'b0;
    end else begin
      d_valid <= f_valid;
    end
  end

  always_ff @(posedge clk) begin
    d_pc        <= f_pc;
    d_op        <= op_n;
    d_dst       <= dst_n;
    d_src       <= src_n;
    d_use_imm   <= use_imm_n;
    d_imm       <= f_instr[3:0];
    d_use_carry <= use_carry_n;
    d_cmp_x     <= cmp_x_n;
    d_cmp_y     <= cmp_y_n;
    d_flag      <= flag_n;
    d_addr_imm  <= f_instr[7:0];
  end

  // Memory-destination forms take r, never an immediate, and target the matching nibble
  a_cmp_form: assert property (@(posedge clk) disable iff (!rst_n)
    d_valid && (d_cmp_x || d_cmp_y) |->
      !d_use_imm && d_use_carry && d_dst[1] && (d_dst[0] == d_cmp_y))
    else $error("memory-destination form decoded with bad operand fields");

endmodule

/* alu/alu_bcd.sv */
`include "e0c62_defs.svh"

module alu_bcd (
  input  e0c62_pkg::nibble_t op_a,
  input  e0c62_pkg::nibble_t op_b,
  input  logic               carry_in,
  input  logic               subtract,
  input  logic               decimal,
  output e0c62_pkg::nibble_t result,
  output logic               carry_out
);

  logic [`E0C62_NIBBLE_W:0] raw;
  logic [`E0C62_NIBBLE_W:0] adj;

  always_comb begin
    if (subtract) begin
      raw       = {1'b0, op_a} - {1'b0, op_b} - carry_in;
      carry_out = raw[`E0C62_NIBBLE_W]; // Borrow
      adj       = (decimal && raw[`E0C62_NIBBLE_W]) ? raw - 5'd6 : raw;
    end else begin
      raw = {1'b0, op_a} + {1'b0, op_b} + carry_in;
      if (decimal && raw >= 5'd10) begin
        adj       = raw + 5'd6; // BCD adjust
        carry_out = 1'b1;
      end else begin
        adj       = raw;
        carry_out = raw[`E0C62_NIBBLE_W];
      end
    end
  end

  assign result = adj[`E0C62_NIBBLE_W-1:0];

endmodule

/* alu/execute_stage.sv */
module execute_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 d_valid,
  input  e0c62_pkg::pc_t       d_pc,
  input  e0c62_pkg::exec_op_t  d_op,
  input  e0c62_pkg::opnd_sel_t d_dst,
  input  e0c62_pkg::opnd_sel_t d_src,
  input  logic                 d_use_imm,
  input  e0c62_pkg::nibble_t   d_imm,
  input  logic                 d_use_carry,
  input  logic                 d_cmp_x,
  input  logic                 d_cmp_y,
  input  e0c62_pkg::flag_sel_t d_flag,
  input  e0c62_pkg::ram_addr_t d_addr_imm,
  input  e0c62_pkg::nibble_t   a,
  input  e0c62_pkg::nibble_t   b,
  input  e0c62_pkg::nibble_t   mx,
  input  e0c62_pkg::nibble_t   my,
  input  e0c62_pkg::ram_addr_t x,
  input  e0c62_pkg::ram_addr_t y,
  input  logic                 carry,
  input  logic                 decimal,
  output logic                 we_a,
  output logic                 we_b,
  output logic                 we_x,
  output logic                 we_y,
  output logic                 we_carry,
  output logic                 we_zero,
  output logic                 we_decimal,
  output e0c62_pkg::nibble_t   wdata,
  output e0c62_pkg::ram_addr_t waddr,
  output logic                 carry_in,
  output logic                 zero_in,
  output logic                 decimal_in,
  output logic                 ram_we,
  output e0c62_pkg::ram_addr_t ram_waddr,
  output e0c62_pkg::nibble_t   ram_wdata,
  output logic                 commit_valid,
  output e0c62_pkg::pc_t       commit_pc
);

  e0c62_pkg::nibble_t dst_val;
  e0c62_pkg::nibble_t src_val;
  e0c62_pkg::nibble_t alu_b;
  e0c62_pkg::nibble_t alu_res;
  e0c62_pkg::nibble_t res;
  logic               alu_cout;
  logic               is_arith;
  logic               is_flag;
  logic               wr_dst;

  always_comb begin
    case (d_dst)
      2'd0:    dst_val = a;
      2'd1:    dst_val = b;
      2'd2:    dst_val = mx;
      default: dst_val = my;
    endcase
    case (d_src)
      2'd0:    src_val = a;
      2'd1:    src_val = b;
      2'd2:    src_val = mx;
      default: src_val = my;
    endcase
  end

  assign alu_b = d_use_imm ? d_imm : src_val;

  alu_bcd alu0 (
    .op_a      (dst_val),
    .op_b      (alu_b),
    .carry_in  (d_use_carry & carry),
    .subtract  (d_op == e0c62_pkg::SUB),
    .decimal   (decimal),
    .result    (alu_res),
    .carry_out (alu_cout)
  );

  assign is_arith = d_valid && (d_op inside {e0c62_pkg::ADD, e0c62_pkg::SUB});
  assign is_flag  = d_valid && (d_op inside {e0c62_pkg::SET_FLAG, e0c62_pkg::CLR_FLAG});
  assign wr_dst   = is_arith || (d_valid && d_op == e0c62_pkg::LOAD_R);
  assign res      = (d_op == e0c62_pkg::LOAD_R) ? d_imm : alu_res;

  always_comb begin
    we_a      = wr_dst && d_dst == 2'd0;
    we_b      = wr_dst && d_dst == 2'd1;
    ram_we    = wr_dst && d_dst[1]; // MX or MY
    ram_waddr = d_dst[0] ? y : x;
    ram_wdata = res;
    wdata     = res;

    we_x = d_valid && (d_op == e0c62_pkg::LOAD_X || d_cmp_x);
    we_y = d_valid && (d_op == e0c62_pkg::LOAD_Y || d_cmp_y);
    if (d_cmp_x) begin
      waddr = e0c62_pkg::ram_addr_t'(x + 1'b1);
    end else if (d_cmp_y) begin
      waddr = e0c62_pkg::ram_addr_t'(y + 1'b1);
    end else begin
      waddr = d_addr_imm;
    end

    we_carry   = is_arith || (is_flag && d_flag == e0c62_pkg::FLAG_CARRY);
    carry_in   = is_arith ? alu_cout : (d_op == e0c62_pkg::SET_FLAG);
    we_zero    = is_arith;
    zero_in    = (alu_res == '0);
    we_decimal = is_flag && d_flag == e0c62_pkg::FLAG_DECIMAL;
    decimal_in = (d_op == e0c62_pkg::SET_FLAG);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      commit_valid <= 1'b0;
    end else begin
      commit_valid <= d_valid;
    end
  end

  always_ff @(posedge clk) begin
    commit_pc <= d_pc;
  end

  // Index bumps of the compare forms ride alongside the RAM write
  a_one_dest: assert property (@(posedge clk) disable iff (!rst_n)
    d_valid |-> $onehot0({we_a, we_b, ram_we, we_x && !d_cmp_x, we_y && !d_cmp_y}))
    else $error("more than one destination written by one instruction");

endmodule

/* verilog/reg_file.sv */
module reg_file (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 we_a,
  input  logic                 we_b,
  input  logic                 we_x,
  input  logic                 we_y,
  input  e0c62_pkg::nibble_t   wdata,
  input  e0c62_pkg::ram_addr_t waddr,
  input  logic                 we_carry,
  input  logic                 carry_in,
  input  logic                 we_zero,
  input  logic                 zero_in,
  input  logic                 we_decimal,
  input  logic                 decimal_in,
  output e0c62_pkg::nibble_t   a,
  output e0c62_pkg::nibble_t   b,
  output e0c62_pkg::ram_addr_t x,
  output e0c62_pkg::ram_addr_t y,
  output logic                 carry,
  output logic                 zero,
  output logic                 decimal
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a       <= '0;
      b       <= '0;
      x       <= '0;
      y       <= '0;
      carry   <= 1'b0;
      zero    <= 1'b0;
      decimal <= 1'b0;
    end else begin
      if (we_a) begin
        a <= wdata;
      end
      if (we_b) begin
        b <= wdata;
      end
      if (we_x) begin
        x <= waddr;
      end
      if (we_y) begin
        y <= waddr;
      end
      if (we_carry) begin
        carry <= carry_in;
      end
      if (we_zero) begin
        zero <= zero_in;
      end
      if (we_decimal) begin
        decimal <= decimal_in;
      end
    end
  end

endmodule

/* verilog/data_ram.sv */
`include "e0c62_defs.svh"

module data_ram (
  input  logic                 clk,
  input  logic                 rst_n,
  input  e0c62_pkg::ram_addr_t x,
  input  e0c62_pkg::ram_addr_t y,
  output e0c62_pkg::nibble_t   mx,
  output e0c62_pkg::nibble_t   my,
  input  logic                 ram_we,
  input  e0c62_pkg::ram_addr_t ram_waddr,
  input  e0c62_pkg::nibble_t   ram_wdata,
  input  e0c62_pkg::ram_addr_t dbg_addr,
  output e0c62_pkg::nibble_t   dbg_data
);

  e0c62_pkg::nibble_t mem [`E0C62_RAM_DEPTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `E0C62_RAM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (ram_we) begin
      mem[ram_waddr] <= ram_wdata;
    end
  end

  assign mx       = mem[x];
  assign my       = mem[y];
  assign dbg_data = mem[dbg_addr]; // Debug peek

endmodule

/* verilog/e0c62_core.sv */
module e0c62_core (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 run,
  output e0c62_pkg::pc_t       rom_addr,
  input  e0c62_pkg::instr_t    rom_data,
  output logic                 commit_valid,
  output e0c62_pkg::pc_t       commit_pc,
  output e0c62_pkg::nibble_t   a,
  output e0c62_pkg::nibble_t   b,
  output e0c62_pkg::ram_addr_t x,
  output e0c62_pkg::ram_addr_t y,
  output logic                 carry,
  output logic                 zero,
  output logic                 decimal,
  input  e0c62_pkg::ram_addr_t dbg_addr,
  output e0c62_pkg::nibble_t   dbg_data
);

  logic                 f_valid;
  e0c62_pkg::pc_t       f_pc;
  e0c62_pkg::instr_t    f_instr;

  logic                 d_valid;
  e0c62_pkg::pc_t       d_pc;
  e0c62_pkg::exec_op_t  d_op;
  e0c62_pkg::opnd_sel_t d_dst;
  e0c62_pkg::opnd_sel_t d_src;
  logic                 d_use_imm;
  e0c62_pkg::nibble_t   d_imm;
  logic                 d_use_carry;
  logic                 d_cmp_x;
  logic                 d_cmp_y;
  e0c62_pkg::flag_sel_t d_flag;
  e0c62_pkg::ram_addr_t d_addr_imm;

  logic                 we_a;
  logic                 we_b;
  logic                 we_x;
  logic                 we_y;
  logic                 we_carry;
  logic                 we_zero;
  logic                 we_decimal;
  e0c62_pkg::nibble_t   wdata;
  e0c62_pkg::ram_addr_t waddr;
  logic                 carry_in;
  logic                 zero_in;
  logic                 decimal_in;

  e0c62_pkg::nibble_t   mx;
  e0c62_pkg::nibble_t   my;
  logic                 ram_we;
  e0c62_pkg::ram_addr_t ram_waddr;
  e0c62_pkg::nibble_t   ram_wdata;

  fetch_stage fetch0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (run),
    .rom_addr (rom_addr),
    .rom_data (rom_data),
    .f_valid  (f_valid),
    .f_pc     (f_pc),
    .f_instr  (f_instr)
  );

  decode_stage decode0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .f_valid     (f_valid),
    .f_pc        (f_pc),
    .f_instr     (f_instr),
    .d_valid     (d_valid),
    .d_pc        (d_pc),
    .d_op        (d_op),
    .d_dst       (d_dst),
    .d_src       (d_src),
    .d_use_imm   (d_use_imm),
    .d_imm       (d_imm),
    .d_use_carry (d_use_carry),
    .d_cmp_x     (d_cmp_x),
    .d_cmp_y     (d_cmp_y),
    .d_flag      (d_flag),
    .d_addr_imm  (d_addr_imm)
  );

  execute_stage exec0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .d_valid      (d_valid),
    .d_pc         (d_pc),
    .d_op         (d_op),
    .d_dst        (d_dst),
    .d_src        (d_src),
    .d_use_imm    (d_use_imm),
    .d_imm        (d_imm),
    .d_use_carry  (d_use_carry),
    .d_cmp_x      (d_cmp_x),
    .d_cmp_y      (d_cmp_y),
    .d_flag       (d_flag),
    .d_addr_imm   (d_addr_imm),
    .a            (a),
    .b            (b),
    .mx           (mx),
    .my           (my),
    .x            (x),
    .y            (y),
    .carry        (carry),
    .decimal      (decimal),
    .we_a         (we_a),
    .we_b         (we_b),
    .we_x         (we_x),
    .we_y         (we_y),
    .we_carry     (we_carry),
    .we_zero      (we_zero),
    .we_decimal   (we_decimal),
    .wdata        (wdata),
    .waddr        (waddr),
    .carry_in     (carry_in),
    .zero_in      (zero_in),
    .decimal_in   (decimal_in),
    .ram_we       (ram_we),
    .ram_waddr    (ram_waddr),
    .ram_wdata    (ram_wdata),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc)
  );

  reg_file regs0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .we_a       (we_a),
    .we_b       (we_b),
    .we_x       (we_x),
    .we_y       (we_y),
    .wdata      (wdata),
    .waddr      (waddr),
    .we_carry   (we_carry),
    .carry_in   (carry_in),
    .we_zero    (we_zero),
    .zero_in    (zero_in),
    .we_decimal (we_decimal),
    .decimal_in (decimal_in),
    .a          (a),
    .b          (b),
    .x          (x),
    .y          (y),
    .carry      (carry),
    .zero       (zero),
    .decimal    (decimal)
  );

  data_ram ram0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .x         (x),
    .y         (y),
    .mx        (mx),
    .my        (my),
    .ram_we    (ram_we),
    .ram_waddr (ram_waddr),
    .ram_wdata (ram_wdata),
    .dbg_addr  (dbg_addr),
    .dbg_data  (dbg_data)
  );

endmodule

/* test/core_model.sv */
`include "e0c62_defs.svh"

package core_model;

  e0c62_pkg::nibble_t   m_a;
  e0c62_pkg::nibble_t   m_b;
  e0c62_pkg::ram_addr_t m_x;
  e0c62_pkg::ram_addr_t m_y;
  logic                 m_carry;
  logic                 m_zero;
  logic                 m_decimal;
  e0c62_pkg::nibble_t   m_mem [`E0C62_RAM_DEPTH];

  // Fixed upper bits of the word equal those of the base
  function automatic bit has_form(e0c62_pkg::instr_t w, e0c62_pkg::instr_t base,
                                  int free_bits);
    return (w >> free_bits) == (base >> free_bits);
  endfunction

  // Returns {carry, result}
  function automatic logic [4:0] add_nibble(e0c62_pkg::nibble_t p, e0c62_pkg::nibble_t q,
                                            logic cin, logic dec);
    int sum;
    sum = int'(p) + int'(q) + int'(cin);
    if (dec && sum >= 10) begin
      return {1'b1, 4'(sum + 6)};
    end
    return {(sum > 15), 4'(sum)};
  endfunction

  function automatic logic [4:0] sub_nibble(e0c62_pkg::nibble_t p, e0c62_pkg::nibble_t q,
                                            logic cin, logic dec);
    int diff;
    diff = int'(p) - int'(q) - int'(cin);
    if (diff < 0) begin
      if (dec) begin
        diff = diff - 6;
      end
      return {1'b1, 4'(diff)};
    end
    return {1'b0, 4'(diff)};
  endfunction

  function automatic e0c62_pkg::nibble_t read_opnd(e0c62_pkg::opnd_sel_t s);
    case (s)
      2'd0:    return m_a;
      2'd1:    return m_b;
      2'd2:    return m_mem[m_x];
      default: return m_mem[m_y];
    endcase
  endfunction

  task automatic write_opnd(input e0c62_pkg::opnd_sel_t s, input e0c62_pkg::nibble_t v);
    case (s)
      2'd0:    m_a = v;
      2'd1:    m_b = v;
      2'd2:    m_mem[m_x] = v;
      default: m_mem[m_y] = v;
    endcase
  endtask

  task automatic reset_state();
    m_a       = '0;
    m_b       = '0;
    m_x       = '0;
    m_y       = '0;
    m_carry   = 1'b0;
    m_zero    = 1'b0;
    m_decimal = 1'b0;
    for (int i = 0; i < `E0C62_RAM_DEPTH; i++) begin
      m_mem[i] = '0;
    end
  endtask

  // One instruction on the architectural state
  task automatic step(input e0c62_pkg::instr_t w);
    logic                 arith;
    logic                 sub;
    logic                 cin;
    logic                 bump_x;
    logic                 bump_y;
    e0c62_pkg::opnd_sel_t dst;
    e0c62_pkg::nibble_t   opb;
    logic [4:0]           r;
    arith  = 1'b1;
    sub    = 1'b0;
    cin    = 1'b0;
    bump_x = 1'b0;
    bump_y = 1'b0;
    dst    = w[3:2];
    opb    = read_opnd(w[1:0]);
    if (has_form(w, `E0C62_OP_ADD_RQ, 4)) begin
    end else if (has_form(w, `E0C62_OP_ADC_RQ, 4)) begin
      cin = m_carry;
    end else if (has_form(w, `E0C62_OP_SUB_RQ, 4)) begin
      sub = 1'b1;
    end else if (has_form(w, `E0C62_OP_SBC_RQ, 4)) begin
      sub = 1'b1;
      cin = m_carry;
    end else if (has_form(w, `E0C62_OP_ADD_RI, 6) || has_form(w, `E0C62_OP_ADC_RI, 6) ||
                 has_form(w, `E0C62_OP_SBC_RI, 6)) begin
      dst = w[5:4];
      opb = w[3:0];
      sub = has_form(w, `E0C62_OP_SBC_RI, 6);
      cin = has_form(w, `E0C62_OP_ADD_RI, 6) ? 1'b0 : m_carry;
    end else if (has_form(w, `E0C62_OP_ACPX, 2) || has_form(w, `E0C62_OP_SCPX, 2)) begin
      dst    = 2'd2;
      sub    = has_form(w, `E0C62_OP_SCPX, 2);
      cin    = m_carry;
      bump_x = 1'b1;
    end else if (has_form(w, `E0C62_OP_ACPY, 2) || has_form(w, `E0C62_OP_SCPY, 2)) begin
      dst    = 2'd3;
      sub    = has_form(w, `E0C62_OP_SCPY, 2);
      cin    = m_carry;
      bump_y = 1'b1;
    end else begin
      arith = 1'b0;
      if (has_form(w, `E0C62_OP_LD_RI, 6)) begin
        write_opnd(w[5:4], w[3:0]);
      end else if (has_form(w, `E0C62_OP_LD_XE, 8)) begin
        m_x = w[7:0];
      end else if (has_form(w, `E0C62_OP_LD_YE, 8)) begin
        m_y = w[7:0];
      end else if (w == `E0C62_OP_SCF) begin
        m_carry = 1'b1;
      end else if (w == `E0C62_OP_RCF) begin
        m_carry = 1'b0;
      end else if (w == `E0C62_OP_SDF) begin
        m_decimal = 1'b1;
      end else if (w == `E0C62_OP_RDF) begin
        m_decimal = 1'b0;
      end
    end
    if (arith) begin
      r = sub ? sub_nibble(read_opnd(dst), opb, cin, m_decimal) :
                add_nibble(read_opnd(dst), opb, cin, m_decimal);
      write_opnd(dst, r[3:0]); // Memory forms store at the old index
      m_carry = r[4];
      m_zero  = (r[3:0] == 4'h0);
      if (bump_x) begin
        m_x = m_x + 1'b1;
      end
      if (bump_y) begin
        m_y = m_y + 1'b1;
      end
    end
  endtask

endpackage

/* test/core_tb.sv */
`include "e0c62_defs.svh"

module core_tb;

  localparam int PROG_LEN    = 400;
  localparam int CYCLE_LIMIT = PROG_LEN * 3 + 16 + 50;

  logic                 clk;
  logic                 rst_n;
  logic                 run;
  e0c62_pkg::pc_t       rom_addr;
  e0c62_pkg::instr_t    rom_data;
  logic                 commit_valid;
  e0c62_pkg::pc_t       commit_pc;
  e0c62_pkg::nibble_t   a;
  e0c62_pkg::nibble_t   b;
  e0c62_pkg::ram_addr_t x;
  e0c62_pkg::ram_addr_t y;
  logic                 carry;
  logic                 zero;
  logic                 decimal;
  e0c62_pkg::ram_addr_t dbg_addr;
  e0c62_pkg::nibble_t   dbg_data;

  e0c62_pkg::instr_t    program_rom [PROG_LEN];
  integer               seed;
  int                   n_errors;
  int                   n_checks;
  int                   committed;
  int                   cycles;
  e0c62_pkg::pc_t       exp_pc;
  e0c62_pkg::pc_t       fetch_pc;
  e0c62_pkg::ram_addr_t old_x;
  e0c62_pkg::ram_addr_t old_y;
  logic [2:0]           run_hist; // Run values of the last three drives

  e0c62_core dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .run          (run),
    .rom_addr     (rom_addr),
    .rom_data     (rom_data),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .a            (a),
    .b            (b),
    .x            (x),
    .y            (y),
    .carry        (carry),
    .zero         (zero),
    .decimal      (decimal),
    .dbg_addr     (dbg_addr),
    .dbg_data     (dbg_data)
  );

  always #10 clk = ~clk;

  task automatic check_pc(input string name, input e0c62_pkg::pc_t expected,
                          input e0c62_pkg::pc_t actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("[ERROR] %s expected %h got %h", name, expected, actual);
    end
  endtask

  task automatic check_nibble(input string name, input e0c62_pkg::nibble_t expected,
                              input e0c62_pkg::nibble_t actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("[ERROR] %s expected %h got %h", name, expected, actual);
    end
  endtask

  task automatic check_addr(input string name, input e0c62_pkg::ram_addr_t expected,
                            input e0c62_pkg::ram_addr_t actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("[ERROR] %s expected %h got %h", name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("[ERROR] %s expected %h got %h", name, expected, actual);
    end
  endtask

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  function automatic e0c62_pkg::instr_t make_instr(input logic [31:0] r);
    int unsigned kind;
    logic [7:0]  e;
    kind = r[31:16] % 20;
    e    = r[8] ? r[7:0] : {4'h0, r[3:0]}; // Mostly low addresses so X and Y collide
    case (kind)
      0:       return `E0C62_OP_ADD_RQ | {8'h00, r[3:0]};
      1:       return `E0C62_OP_ADC_RQ | {8'h00, r[3:0]};
      2:       return `E0C62_OP_SUB_RQ | {8'h00, r[3:0]};
      3:       return `E0C62_OP_SBC_RQ | {8'h00, r[3:0]};
      4:       return `E0C62_OP_ADD_RI | {6'h00, r[5:0]};
      5:       return `E0C62_OP_ADC_RI | {6'h00, r[5:0]};
      6:       return `E0C62_OP_SBC_RI | {6'h00, r[5:0]};
      7:       return `E0C62_OP_ACPX | {10'h000, r[1:0]};
      8:       return `E0C62_OP_ACPY | {10'h000, r[1:0]};
      9:       return `E0C62_OP_SCPX | {10'h000, r[1:0]};
      10:      return `E0C62_OP_SCPY | {10'h000, r[1:0]};
      11, 12:  return `E0C62_OP_LD_RI | {6'h00, r[5:0]};
      13:      return `E0C62_OP_LD_XE | {4'h0, e};
      14:      return `E0C62_OP_LD_YE | {4'h0, e};
      15:      return `E0C62_OP_SCF;
      16:      return `E0C62_OP_RCF;
      17:      return `E0C62_OP_SDF;
      18:      return `E0C62_OP_RDF;
      default: return {1'b0, r[10:0]}; // Unsupported word retires as NOP
    endcase
  endfunction

  task automatic fill_program();
    for (int i = 0; i < PROG_LEN; i++) begin
      program_rom[i] = make_instr(next_rand());
    end
  endtask

  // Random run gaps and the ROM word at the current address
  task automatic drive_inputs();
    logic [31:0] r;
    int          idx;
    check_pc("rom_addr", fetch_pc, rom_addr);
    r        = next_rand();
    idx      = int'(rom_addr);
    run      = (r[2:0] != 3'd0);
    run_hist = {run_hist[1:0], run};
    rom_data = (idx < PROG_LEN) ? program_rom[idx] : 12'h000;
    if (run) begin
      fetch_pc = fetch_pc + 1'b1; // Fetch advances at the next rising edge
    end
  endtask

  task automatic compare_state();
    check_nibble("a", core_model::m_a, a);
    check_nibble("b", core_model::m_b, b);
    check_addr("x", core_model::m_x, x);
    check_addr("y", core_model::m_y, y);
    check_flag("carry", core_model::m_carry, carry);
    check_flag("zero", core_model::m_zero, zero);
    check_flag("decimal", core_model::m_decimal, decimal);
    dbg_addr = old_x;
    #1;
    check_nibble("ram_at_x", core_model::m_mem[old_x], dbg_data);
    dbg_addr = old_y;
    #1;
    check_nibble("ram_at_y", core_model::m_mem[old_y], dbg_data);
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    run       = 1'b0;
    rom_data  = '0;
    dbg_addr  = '0;
    seed      = 32'h8b69a901;
    n_errors  = 0;
    n_checks  = 0;
    committed = 0;
    exp_pc    = '0;
    fetch_pc  = '0;
    run_hist  = '0;
    core_model::reset_state();
    fill_program();
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    drive_inputs();
    while (committed < PROG_LEN) begin
      @(negedge clk);
      old_x = core_model::m_x;
      old_y = core_model::m_y;
      check_flag("commit_valid", run_hist[2], commit_valid); // Three stages behind run
      if (commit_valid) begin
        check_pc("commit_pc", exp_pc, commit_pc);
        core_model::step(program_rom[int'(exp_pc)]);
        exp_pc = exp_pc + 1'b1;
        committed++;
      end
      drive_inputs();
      compare_state();
    end
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, only %0d of %0d instructions committed",
             cycles, committed, PROG_LEN);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+common
common/e0c62_pkg.sv
verilog/fetch_stage.sv
decode/decode_stage.sv
alu/alu_bcd.sv
alu/execute_stage.sv
verilog/reg_file.sv
verilog/data_ram.sv
verilog/e0c62_core.sv
test/core_model.sv
test/core_tb.sv
